/* pkt_mon_pkg.sv */
////////////////////////////////////////////////////////////
// Shared widths and types for the packet accounting monitor
// Compiled ahead of every monitor module
////////////////////////////////////////////////////////////

package pkt_mon_pkg;

    ////////////////////////////////////////////////////////////
    // Widths

    // One per-port packet counter, wraps at 2**16
    localparam int CNT_WIDTH = 16;

    // Direction totals and in-flight count
    localparam int TOTAL_WIDTH = 20;

    typedef logic [CNT_WIDTH-1:0]   cnt_t;
    typedef logic [TOTAL_WIDTH-1:0] total_t;

    ////////////////////////////////////////////////////////////
    // Port and status words

    // Beat control of one port for one cycle
    typedef struct packed {
        logic valid;
        logic ready;
        logic last;
    } beat_t;

    // Monitor status as seen by the host
    typedef struct packed {
        // Ingress total minus egress total
        total_t in_flight;
        // Egress quiet and nothing outstanding
        logic   drained;
        // Sticky until reset
        logic   underflow;
    } mon_status_t;

endpackage

/* port_pkt_counter_bank.sv */
////////////////////////////////////////////////////////////
// Per-port completed packet counters for one direction
// Feeds per-cycle completions to the balance unit
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module port_pkt_counter_bank #(
    parameter int    NUM_PORTS      = 4,
    parameter int    PORT_SEL_WIDTH = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1,
    localparam int   DONE_WIDTH     = $clog2(NUM_PORTS + 1)
) (
    input  logic                               phys_port_clk_ifc,
    input  logic                               arst_n,

    input  pkt_mon_pkg::beat_t [NUM_PORTS-1:0] beats,
    input  logic [NUM_PORTS-1:0]               enable,

    input  logic [PORT_SEL_WIDTH-1:0]          rd_port,
    output pkt_mon_pkg::cnt_t                  rd_count,

    output logic [DONE_WIDTH-1:0]              done_count,
    output logic                               any_valid
);

    import pkt_mon_pkg::*;

    logic [NUM_PORTS-1:0]  done_strobe;
    logic [NUM_PORTS-1:0]  valid_bits;
    logic [DONE_WIDTH-1:0] done_sum;

    cnt_t port_cnt [NUM_PORTS];


    ////////////////////////////////////////////////////////////
    // Beat decode

    // Packet ends on a handshaked last beat of an enabled port
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            done_strobe[p] = enable[p] & beats[p].valid & beats[p].ready & beats[p].last;
            valid_bits[p]  = enable[p] & beats[p].valid;
        end
    end

    // Completions this cycle
    always_comb begin
        done_sum = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            done_sum = done_sum + DONE_WIDTH'(done_strobe[p]);
        end
    end


    ////////////////////////////////////////////////////////////
    // Counters

    always_ff @(posedge phys_port_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                port_cnt[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (done_strobe[p]) begin
                    port_cnt[p] <= port_cnt[p] + cnt_t'(1);
                end
            end
        end
    end

    always_ff @(posedge phys_port_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            done_count <= '0;
            any_valid  <= 1'b0;
        end else begin
            done_count <= done_sum;
            any_valid  <= |valid_bits;
        end
    end


    ////////////////////////////////////////////////////////////
    // Host readout

    // Value before this edge's increment; unused index reads zero
    always_ff @(posedge phys_port_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            rd_count <= '0;
        end else if (int'(rd_port) < NUM_PORTS) begin
            rd_count <= port_cnt[rd_port];
        end else begin
            rd_count <= '0;
        end
    end

endmodule

/* traffic_balance.sv */
////////////////////////////////////////////////////////////
// Direction totals and in-flight, drained, underflow status
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module traffic_balance #(
    parameter int  NUM_ING_PORTS = 4,
    parameter int  NUM_EGR_PORTS = 4,
    parameter int  IDLE_WINDOW   = 16,
    localparam int ING_DONE_WIDTH = $clog2(NUM_ING_PORTS + 1),
    localparam int EGR_DONE_WIDTH = $clog2(NUM_EGR_PORTS + 1)
) (
    input  logic                        phys_port_clk_ifc,
    input  logic                        arst_n,

    input  logic [ING_DONE_WIDTH-1:0]   ing_done,
    input  logic [EGR_DONE_WIDTH-1:0]   egr_done,
    input  logic                        egr_any_valid,

    output pkt_mon_pkg::total_t         ing_total,
    output pkt_mon_pkg::total_t         egr_total,
    output pkt_mon_pkg::mon_status_t    status
);

    import pkt_mon_pkg::*;

    localparam int QUIET_WIDTH = (IDLE_WINDOW > 0) ? $clog2(IDLE_WINDOW + 1) : 1;
    localparam logic [QUIET_WIDTH-1:0] QUIET_MAX = QUIET_WIDTH'(IDLE_WINDOW);

    total_t                 in_flight;
    logic                   borrow;
    logic                   underflow_q;
    logic                   quiet_done;
    logic [QUIET_WIDTH-1:0] quiet_cnt;


    ////////////////////////////////////////////////////////////
    // Totals

    always_ff @(posedge phys_port_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            ing_total <= '0;
            egr_total <= '0;
        end else begin
            ing_total <= ing_total + TOTAL_WIDTH'(ing_done);
            egr_total <= egr_total + TOTAL_WIDTH'(egr_done);
        end
    end

    // Extra top bit catches egress running ahead of ingress
    assign {borrow, in_flight} = {1'b0, ing_total} - {1'b0, egr_total};


    ////////////////////////////////////////////////////////////
    // Drain detection

    // Counts quiet egress cycles up to the window
    always_ff @(posedge phys_port_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            quiet_cnt <= '0;
        end else if (egr_any_valid) begin
            quiet_cnt <= '0;
        end else if (quiet_cnt != QUIET_MAX) begin
            quiet_cnt <= quiet_cnt + 1'b1;
        end
    end

    assign quiet_done = (quiet_cnt == QUIET_MAX);


    ////////////////////////////////////////////////////////////
    // Underflow

    always_ff @(posedge phys_port_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            underflow_q <= 1'b0;
        end else if (borrow) begin
            underflow_q <= 1'b1;
        end
    end

    // Flag shows in the same cycle as the borrowing totals
    assign status = '{
        in_flight: in_flight,
        drained:   quiet_done && (in_flight == '0),
        underflow: underflow_q | borrow
    };

endmodule

/* pkt_mon_top.sv */
////////////////////////////////////////////////////////////
// Packet accounting monitor for router ingress and egress
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pkt_mon_top #(
    parameter int  NUM_ING_PORTS  = 4,
    parameter int  NUM_EGR_PORTS  = 4,
    parameter int  IDLE_WINDOW    = 16,
    localparam int MAX_PORTS      = (NUM_ING_PORTS > NUM_EGR_PORTS) ? NUM_ING_PORTS
                                                                    : NUM_EGR_PORTS,
    localparam int PORT_SEL_WIDTH = (MAX_PORTS > 1) ? $clog2(MAX_PORTS) : 1
) (
    input  logic                                   phys_port_clk_ifc,
    input  logic                                   arst_n,

    input  pkt_mon_pkg::beat_t [NUM_ING_PORTS-1:0] ing_beats,
    input  pkt_mon_pkg::beat_t [NUM_EGR_PORTS-1:0] egr_beats,
    input  logic [NUM_ING_PORTS-1:0]               ing_enable,
    input  logic [NUM_EGR_PORTS-1:0]               egr_enable,

    input  logic                                   rd_egr,
    input  logic [PORT_SEL_WIDTH-1:0]              rd_port,
    output pkt_mon_pkg::cnt_t                      rd_count,

    output pkt_mon_pkg::total_t                    ing_total,
    output pkt_mon_pkg::total_t                    egr_total,
    output pkt_mon_pkg::mon_status_t               status
);

    import pkt_mon_pkg::*;

    cnt_t                               ing_rd_count;
    cnt_t                               egr_rd_count;
    logic [$clog2(NUM_ING_PORTS+1)-1:0] ing_done;
    logic [$clog2(NUM_EGR_PORTS+1)-1:0] egr_done;
    logic                               egr_any_valid;


    ////////////////////////////////////////////////////////////
    // Counter banks

    port_pkt_counter_bank #(
        .NUM_PORTS      ( NUM_ING_PORTS  ),
        .PORT_SEL_WIDTH ( PORT_SEL_WIDTH )
    ) ing_bank (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .arst_n            ( arst_n            ),
        .beats             ( ing_beats         ),
        .enable            ( ing_enable        ),
        .rd_port           ( rd_port           ),
        .rd_count          ( ing_rd_count      ),
        .done_count        ( ing_done          ),
        .any_valid         (                   )
    );

    port_pkt_counter_bank #(
        .NUM_PORTS      ( NUM_EGR_PORTS  ),
        .PORT_SEL_WIDTH ( PORT_SEL_WIDTH )
    ) egr_bank (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .arst_n            ( arst_n            ),
        .beats             ( egr_beats         ),
        .enable            ( egr_enable        ),
        .rd_port           ( rd_port           ),
        .rd_count          ( egr_rd_count      ),
        .done_count        ( egr_done          ),
        .any_valid         ( egr_any_valid     )
    );

    assign rd_count = rd_egr ? egr_rd_count : ing_rd_count;


    ////////////////////////////////////////////////////////////
    // Balance

    traffic_balance #(
        .NUM_ING_PORTS ( NUM_ING_PORTS ),
        .NUM_EGR_PORTS ( NUM_EGR_PORTS ),
        .IDLE_WINDOW   ( IDLE_WINDOW   )
    ) balance (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .arst_n            ( arst_n            ),
        .ing_done          ( ing_done          ),
        .egr_done          ( egr_done          ),
        .egr_any_valid     ( egr_any_valid     ),
        .ing_total         ( ing_total         ),
        .egr_total         ( egr_total         ),
        .status            ( status            )
    );

endmodule

/* tb_clock_gen.sv */
////////////////////////////////////////////////////////////
// Testbench clock and reset, 100 ns period, 8 reset cycles
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_clock_gen (
    output logic phys_port_clk_ifc,
    output logic arst_n
);

    // Also called by the testbench top for a second reset
    task automatic apply_reset();
        arst_n = 1'b0;
        repeat (8) @(posedge phys_port_clk_ifc);
        #1 arst_n = 1'b1;
    endtask

    initial begin
        phys_port_clk_ifc = 1'b0;
        forever #50 phys_port_clk_ifc = ~phys_port_clk_ifc;
    end

    initial begin
        apply_reset();
    end

endmodule

/* tb_pkt_mon_checker.sv */
////////////////////////////////////////////////////////////
// Watches the monitor, keeps model counters and compares
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_pkt_mon_checker (
    input logic                     phys_port_clk_ifc,
    input logic                     arst_n,
    input pkt_mon_pkg::beat_t [3:0] ing_beats,
    input pkt_mon_pkg::beat_t [3:0] egr_beats,
    input logic [3:0]               ing_enable,
    input logic [3:0]               egr_enable,
    input pkt_mon_pkg::cnt_t        rd_count,
    input pkt_mon_pkg::total_t      ing_total,
    input pkt_mon_pkg::total_t      egr_total,
    input pkt_mon_pkg::mon_status_t status
);

    import pkt_mon_pkg::*;

    longint m_ing_cnt [4];
    longint m_egr_cnt [4];
    longint m_ing_total;
    longint m_egr_total;
    logic   m_underflow;
    int     error_count = 0;
    int     errors_at_start = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;

    // Packet completes on valid, ready and last of an enabled port
    function automatic logic [3:0] completions(input beat_t [3:0] b, input logic [3:0] en);
        logic [3:0] inc;
        for (int p = 0; p < 4; p++) begin
            inc[p] = en[p] && b[p].valid && b[p].ready && b[p].last;
        end
        return inc;
    endfunction

    always @(posedge phys_port_clk_ifc or negedge arst_n) begin
        logic [3:0] ing_inc;
        logic [3:0] egr_inc;
        if (!arst_n) begin
            for (int p = 0; p < 4; p++) begin
                m_ing_cnt[p] = 0;
                m_egr_cnt[p] = 0;
            end
            m_ing_total = 0;
            m_egr_total = 0;
            m_underflow = 1'b0;
        end else begin
            ing_inc = completions(ing_beats, ing_enable);
            egr_inc = completions(egr_beats, egr_enable);
            for (int p = 0; p < 4; p++) begin
                m_ing_cnt[p] += ing_inc[p];
                m_egr_cnt[p] += egr_inc[p];
                m_ing_total += ing_inc[p];
                m_egr_total += egr_inc[p];
            end
            if (m_egr_total > m_ing_total) begin
                m_underflow = 1'b1;
            end
        end
    end

    task automatic check_value(input string what, input longint got, input longint exp);
        if (got != exp) begin
            $display("error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            error_count++;
        end
    endtask

    // rd_count registered one edge after rd_port was set
    task automatic check_read(input bit egr, input int port);
        longint exp;
        exp = egr ? m_egr_cnt[port] : m_ing_cnt[port];
        check_value($sformatf("%s rd_count port %0d", egr ? "egress" : "ingress", port),
                    rd_count, exp & 64'hFFFF);
    endtask

    task automatic check_totals();
        check_value("ing_total", ing_total, m_ing_total & 64'hFFFFF);
        check_value("egr_total", egr_total, m_egr_total & 64'hFFFFF);
        check_value("in_flight", status.in_flight, (m_ing_total - m_egr_total) & 64'hFFFFF);
        check_value("underflow", status.underflow, m_underflow);
    endtask

    task automatic note_timeout(input string what);
        $display("timeout at %0d ns: %s", $time, what);
        error_count++;
    endtask

    task automatic end_test(input string name);
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    task automatic report_counts();
        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
    endtask

endmodule

/* tb_pkt_mon.sv */
////////////////////////////////////////////////////////////
// Testbench top for the packet accounting monitor
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_pkt_mon;

    import pkt_mon_pkg::*;

    localparam int IDLE_WINDOW = 16;

    logic        phys_port_clk_ifc;
    logic        arst_n;
    beat_t [3:0] ing_beats;
    beat_t [3:0] egr_beats;
    logic [3:0]  ing_enable;
    logic [3:0]  egr_enable;
    logic        rd_egr;
    logic [1:0]  rd_port;
    cnt_t        rd_count;
    total_t      ing_total;
    total_t      egr_total;
    mon_status_t status;
    integer      seed = 32'h90ff;
    int          waited;
    int          n_egr;

    tb_clock_gen clk_gen (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .arst_n            ( arst_n            )
    );

    pkt_mon_top #(
        .NUM_ING_PORTS ( 4           ),
        .NUM_EGR_PORTS ( 4           ),
        .IDLE_WINDOW   ( IDLE_WINDOW )
    ) uut (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .arst_n            ( arst_n            ),
        .ing_beats         ( ing_beats         ),
        .egr_beats         ( egr_beats         ),
        .ing_enable        ( ing_enable        ),
        .egr_enable        ( egr_enable        ),
        .rd_egr            ( rd_egr            ),
        .rd_port           ( rd_port           ),
        .rd_count          ( rd_count          ),
        .ing_total         ( ing_total         ),
        .egr_total         ( egr_total         ),
        .status            ( status            )
    );

    tb_pkt_mon_checker chk (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .arst_n            ( arst_n            ),
        .ing_beats         ( ing_beats         ),
        .egr_beats         ( egr_beats         ),
        .ing_enable        ( ing_enable        ),
        .egr_enable        ( egr_enable        ),
        .rd_count          ( rd_count          ),
        .ing_total         ( ing_total         ),
        .egr_total         ( egr_total         ),
        .status            ( status            )
    );

    ////////////////////////////////////////////////////////////
    // Stimulus helpers

    // Next drive point, beats cleared
    task automatic next_cycle();
        @(posedge phys_port_clk_ifc);
        #1;
        ing_beats = '0;
        egr_beats = '0;
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic random_traffic(input bit egr, input int ncycles);
        logic [31:0] rnd;
        repeat (ncycles) begin
            next_cycle();
            for (int p = 0; p < 4; p++) begin
                rnd = $random(seed);
                if (egr) begin
                    egr_beats[p].valid = rnd[0];
                    egr_beats[p].ready = rnd[1];
                    egr_beats[p].last  = rnd[2];
                end else begin
                    ing_beats[p].valid = rnd[0];
                    ing_beats[p].ready = rnd[1];
                    ing_beats[p].last  = rnd[2];
                end
            end
        end
    endtask

    task automatic send_packet(input bit egr, input int port, input int nbeats);
        for (int i = 0; i < nbeats; i++) begin
            next_cycle();
            if (egr) begin
                egr_beats[port] = '{valid: 1'b1, ready: 1'b1, last: (i == nbeats - 1)};
            end else begin
                ing_beats[port] = '{valid: 1'b1, ready: 1'b1, last: (i == nbeats - 1)};
            end
        end
    endtask

    task automatic read_all(input bit egr);
        rd_egr = egr;
        for (int p = 0; p < 4; p++) begin
            rd_port = p[1:0];
            next_cycle();
            chk.check_read(egr, p);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Tests

    initial begin
        ing_beats  = '0;
        egr_beats  = '0;
        ing_enable = 4'hF;
        egr_enable = 4'hF;
        rd_egr     = 1'b0;
        rd_port    = '0;

        waited = 0;
        while (arst_n !== 1'b1 && waited < 20) begin
            next_cycle();
            waited++;
        end
        if (arst_n !== 1'b1) begin
            chk.note_timeout("reset was not released after 20 cycles");
        end

        random_traffic(0, 80);
        idle(3);
        read_all(0);
        chk.check_totals();
        chk.end_test("ingress counts");

        // Ports 1 and 3 off, plus stalled and non-last beats
        ing_enable = 4'b0101;
        next_cycle();
        ing_beats[0] = '{valid: 1'b1, ready: 1'b0, last: 1'b1};
        ing_beats[2] = '{valid: 1'b1, ready: 1'b1, last: 1'b0};
        ing_beats[1] = '{valid: 1'b1, ready: 1'b1, last: 1'b1};
        ing_beats[3] = '{valid: 1'b1, ready: 1'b1, last: 1'b1};
        random_traffic(0, 40);
        idle(3);
        read_all(0);
        chk.check_totals();
        ing_enable = 4'hF;
        chk.end_test("gating");

        n_egr = int'(chk.m_ing_total - chk.m_egr_total) - 5;
        for (int i = 0; i < n_egr; i++) begin
            send_packet(1, i % 4, 1 + i % 3);
        end
        idle(2);
        read_all(1);
        chk.check_totals();
        chk.end_test("egress totals");

        for (int i = 0; i < IDLE_WINDOW + 4; i++) begin
            next_cycle();
            chk.check_value("drained with packets in flight", status.drained, 0);
        end
        for (int i = 0; i < 5; i++) begin
            send_packet(1, i % 4, 2);
        end
        waited = 0;
        next_cycle();
        while (!status.drained && waited < IDLE_WINDOW + 3) begin
            next_cycle();
            waited++;
        end
        if (!status.drained) begin
            chk.note_timeout("drained did not rise after egress went quiet");
        end
        chk.check_totals();
        next_cycle();
        egr_beats[0] = '{valid: 1'b1, ready: 1'b0, last: 1'b0};
        waited = 0;
        while (status.drained && waited < 4) begin
            next_cycle();
            waited++;
        end
        if (status.drained) begin
            chk.note_timeout("drained did not fall after a new egress valid");
        end
        chk.end_test("drained");

        send_packet(1, 1, 1);
        idle(3);
        chk.check_totals();
        chk.check_value("underflow after extra egress packet", status.underflow, 1);
        // Ingress catches up so totals balance again
        send_packet(0, 2, 2);
        send_packet(0, 3, 1);
        send_packet(1, 2, 3);
        idle(3);
        chk.check_totals();
        chk.check_value("in_flight after balanced traffic", status.in_flight, 0);
        chk.check_value("underflow after balanced traffic", status.underflow, 1);
        clk_gen.apply_reset();
        idle(1);
        chk.check_value("ing_total after reset", ing_total, 0);
        chk.check_value("egr_total after reset", egr_total, 0);
        chk.check_value("status after reset", status, 0);
        read_all(0);
        read_all(1);
        chk.end_test("underflow and reset");

        chk.report_counts();
        if (chk.error_count == 0 && chk.tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
pkt_mon_pkg.sv
port_pkt_counter_bank.sv
traffic_balance.sv
pkt_mon_top.sv
tb_clock_gen.sv
tb_pkt_mon_checker.sv
tb_pkt_mon.sv
